// ==== rtl/fcvt_defines.svh ====
`ifndef FCVT_DEFINES_SVH
`define FCVT_DEFINES_SVH

// ----------------------------------------
// binary32 format
// ----------------------------------------
`define FCVT_WIDTH     32   // Operand and result width
`define FCVT_EXP_BITS  8    // Float exponent field
`define FCVT_MAN_BITS  23   // Float fraction field
`define FCVT_BIAS      127

// ----------------------------------------
// Internal datapath
// ----------------------------------------
// Wide enough for the implicit bit plus fraction or a full integer
`define FCVT_MAN_W     32
`define FCVT_EXP_W     10   // Signed, covers smallest subnormal
`define FCVT_SHAMT_W   5    // Leading-zero count

`endif

// ==== rtl/fcvt_pkg.sv ====
`default_nettype none

`include "fcvt_defines.svh"

package fcvt_pkg;

  // ----------------------------------------
  // Datapath vectors
  // ----------------------------------------
  typedef logic [`FCVT_WIDTH-1:0]        word_t;   // Operand or result
  typedef logic [`FCVT_MAN_W-1:0]        man_t;    // Normalized mantissa
  typedef logic signed [`FCVT_EXP_W-1:0] exp_t;    // Unbiased exponent
  typedef logic [1:0]                    rs_t;     // Round, sticky
  typedef logic [4:0]                    status_t; // NV DZ OF UF NX

  // Status bit positions
  localparam int unsigned ST_NV = 4;
  localparam int unsigned ST_DZ = 3;
  localparam int unsigned ST_OF = 2;
  localparam int unsigned ST_UF = 1;
  localparam int unsigned ST_NX = 0;

  // ----------------------------------------
  // Operation and rounding mode
  // ----------------------------------------
  typedef enum logic {
    F2I = 1'b0,  // binary32 to integer
    I2F = 1'b1   // Integer to binary32
  } op_e;

  // IEEE / RISC-V rm encoding
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rnd_e;

endpackage

`default_nettype wire

// ==== rtl/fcvt_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcvt_defines.svh"

module fcvt_unpack import fcvt_pkg::*; (
  input  word_t operand_i,
  input  op_e   op_i,
  input  logic  op_mod_i,    // Unsigned integer
  output logic  sign_o,
  output exp_t  exp_o,       // Unbiased
  output man_t  mant_o,      // MSB set unless zero
  output logic  mant_zero_o,
  output logic  is_nan_o,
  output logic  is_snan_o,
  output logic  is_inf_o,
  output logic  is_zero_o
);

  logic [`FCVT_EXP_BITS-1:0] f_exp;
  logic [`FCVT_MAN_BITS-1:0] f_man;
  logic                      exp_ones;
  logic                      exp_zero;
  logic                      man_zero;
  logic                      is_f2i;
  logic                      int_sign;
  word_t                     int_mag;
  man_t                      mant_raw;
  logic [`FCVT_SHAMT_W-1:0]  lz_cnt;
  exp_t                      fp_exp;
  exp_t                      int_exp;

  // ----------------------------------------
  // Float classification
  // ----------------------------------------
  assign f_exp    = operand_i[`FCVT_WIDTH-2 -: `FCVT_EXP_BITS];
  assign f_man    = operand_i[`FCVT_MAN_BITS-1:0];
  assign exp_ones = &f_exp;
  assign exp_zero = ~|f_exp;
  assign man_zero = ~|f_man;
  assign is_f2i   = (op_i == F2I);

  // Integer sources never carry a class
  assign is_nan_o  = is_f2i & exp_ones & ~man_zero;
  assign is_snan_o = is_nan_o & ~f_man[`FCVT_MAN_BITS-1]; // Quiet bit clear
  assign is_inf_o  = is_f2i & exp_ones & man_zero;
  assign is_zero_o = is_f2i & exp_zero & man_zero;

  // Integer magnitude, sign only for signed ints
  assign int_sign = operand_i[`FCVT_WIDTH-1] & ~op_mod_i;
  assign int_mag  = int_sign ? word_t'(-operand_i) : operand_i;

  // Implicit bit in front of the fraction, right aligned
  assign mant_raw = is_f2i ? man_t'({~exp_zero, f_man}) : man_t'(int_mag);

  // ----------------------------------------
  // Leading-zero count and renormalization
  // ----------------------------------------
  always_comb begin
    lz_cnt = '0;
    for (int i = 0; i < `FCVT_MAN_W; i++) begin
      if (mant_raw[i]) lz_cnt = `FCVT_SHAMT_W'(`FCVT_MAN_W - 1 - i); // Highest one wins
    end
  end

  assign mant_zero_o = ~|mant_raw;
  assign mant_o      = mant_raw << lz_cnt;

  // Subnormals use exponent 1, shift undoes the right alignment
  assign fp_exp  = exp_t'({2'b00, f_exp}) + exp_t'(exp_zero) - exp_t'(`FCVT_BIAS)
                   - exp_t'(lz_cnt) + exp_t'(`FCVT_MAN_W - 1 - `FCVT_MAN_BITS);
  assign int_exp = exp_t'(`FCVT_MAN_W - 1) - exp_t'(lz_cnt);

  assign exp_o  = is_f2i ? fp_exp : int_exp;
  assign sign_o = is_f2i ? operand_i[`FCVT_WIDTH-1] : int_sign;

  // LZC and shifter must leave a normalized mantissa
  always_comb begin
    if (!$isunknown(operand_i)) begin
      assert (mant_zero_o || mant_o[`FCVT_MAN_W-1])
        else $error("fcvt_unpack: mantissa not normalized for %h", operand_i);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fcvt_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcvt_defines.svh"

module fcvt_align import fcvt_pkg::*; (
  input  op_e   op_i,
  input  logic  op_mod_i,
  input  logic  sign_i,
  input  exp_t  exp_i,
  input  man_t  mant_i,
  input  logic  is_inf_i,
  output word_t abs_o,       // Magnitude before rounding
  output rs_t   rs_o,
  output logic  of_before_o,
  output logic  uf_before_o
);

  exp_t                      dst_exp;    // Rebiased for binary32
  logic [`FCVT_EXP_BITS-1:0] final_exp;
  logic [2*`FCVT_MAN_W:0]    pre_mant;   // Mantissa left, room to shift out
  logic [2*`FCVT_MAN_W:0]    dst_mant;
  logic [`FCVT_SHAMT_W:0]    shamt;
  word_t                     int_val;
  logic [`FCVT_MAN_BITS-1:0] fp_man;
  rs_t                       int_rs;
  rs_t                       fp_rs;

  assign dst_exp = exp_i + exp_t'(`FCVT_BIAS);

  // ----------------------------------------
  // Shift amount and range checks
  // ----------------------------------------
  always_comb begin
    final_exp   = dst_exp[`FCVT_EXP_BITS-1:0];
    pre_mant    = {mant_i, {(`FCVT_MAN_W+1){1'b0}}};
    shamt       = '0;
    of_before_o = 1'b0;
    uf_before_o = 1'b0;

    if (op_i == F2I) begin
      // Integer point sits right of bit 31-exp
      shamt = (`FCVT_SHAMT_W+1)'(exp_t'(`FCVT_WIDTH - 1) - exp_i);
      // Unsigned range one bit larger, negative unsigned >= 1 invalid
      if (is_inf_i || (exp_i >= exp_t'(`FCVT_WIDTH - 1) + exp_t'(op_mod_i)) ||
          (op_mod_i && sign_i && exp_i >= 0)) begin
        shamt       = '0;
        of_before_o = 1'b1;
      end else if (exp_i < -1) begin
        shamt       = (`FCVT_SHAMT_W+1)'(`FCVT_WIDTH + 1); // Everything into sticky
        uf_before_o = 1'b1;
      end
    end else begin
      if (dst_exp >= exp_t'((1 << `FCVT_EXP_BITS) - 1)) begin
        final_exp   = {{(`FCVT_EXP_BITS-1){1'b1}}, 1'b0}; // Largest normal
        pre_mant    = '1;                                 // R and S set too
        of_before_o = 1'b1;
      end else if (dst_exp < 1 && dst_exp >= -`FCVT_MAN_BITS) begin
        final_exp   = '0;                                 // Denormal result
        shamt       = (`FCVT_SHAMT_W+1)'(exp_t'(1) - dst_exp);
        uf_before_o = 1'b1;
      end else if (dst_exp < -`FCVT_MAN_BITS) begin
        final_exp   = '0;
        shamt       = (`FCVT_SHAMT_W+1)'(`FCVT_MAN_BITS + 1); // Keep only sticky
        uf_before_o = 1'b1;
      end
    end
  end

  assign dst_mant = pre_mant >> shamt;

  // ----------------------------------------
  // Field extraction
  // ----------------------------------------
  assign int_val = dst_mant[2*`FCVT_MAN_W -: `FCVT_WIDTH];
  assign int_rs  = {dst_mant[2*`FCVT_MAN_W-`FCVT_WIDTH],
                    |dst_mant[2*`FCVT_MAN_W-`FCVT_WIDTH-1:0]};

  // Implicit bit at the top is dropped
  assign fp_man = dst_mant[2*`FCVT_MAN_W-1 -: `FCVT_MAN_BITS];
  assign fp_rs  = {dst_mant[2*`FCVT_MAN_W-1-`FCVT_MAN_BITS],
                   |dst_mant[2*`FCVT_MAN_W-2-`FCVT_MAN_BITS:0]};

  assign abs_o = (op_i == F2I) ? int_val : word_t'({final_exp, fp_man});
  assign rs_o  = (op_i == F2I) ? int_rs : fp_rs;

endmodule

`default_nettype wire

// ==== rtl/fcvt_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fcvt_defines.svh"

module fcvt_round import fcvt_pkg::*; (
  input  op_e     op_i,
  input  logic    op_mod_i,
  input  rnd_e    rnd_i,
  input  logic    sign_i,
  input  logic    mant_zero_i,
  input  logic    is_nan_i,
  input  logic    is_snan_i,
  input  logic    is_inf_i,
  input  logic    is_zero_i,
  input  word_t   abs_i,
  input  rs_t     rs_i,
  input  logic    of_before_i,
  input  logic    uf_before_i,
  output word_t   result_o,
  output status_t status_o
);

  logic                      round_up;
  word_t                     rounded_abs;
  logic                      rounded_zero;
  logic [`FCVT_EXP_BITS-1:0] res_exp;
  logic                      of_after;
  logic                      uf_after;
  word_t                     fp_res;
  word_t                     int_res;
  word_t                     int_sat;
  logic                      neg_unsigned;
  logic                      int_special;
  status_t                   fp_status;
  status_t                   int_status;

  // ----------------------------------------
  // Rounding
  // ----------------------------------------
  always_comb begin
    case (rnd_i)
      RNE:     round_up = rs_i[1] & (rs_i[0] | abs_i[0]); // Ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_i) & sign_i;
      RUP:     round_up = (|rs_i) & ~sign_i;
      RMM:     round_up = rs_i[1];                        // Ties away
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs  = abs_i + word_t'(round_up); // Carry may bump exponent
  assign rounded_zero = (rounded_abs == '0);

  // Float result checks after rounding
  assign res_exp  = rounded_abs[`FCVT_WIDTH-2 -: `FCVT_EXP_BITS];
  assign uf_after = (res_exp == '0) & ~rounded_zero;
  assign of_after = &res_exp;

  // Integer zero gives +0
  assign fp_res = mant_zero_i ? '0 : {sign_i, rounded_abs[`FCVT_WIDTH-2:0]};

  always_comb begin
    fp_status        = '0;
    fp_status[ST_NV] = of_before_i | of_after;       // Out of range int is invalid
    fp_status[ST_OF] = 1'b0;                         // Reported through NV
    fp_status[ST_UF] = ~mant_zero_i & (uf_before_i | uf_after);
    fp_status[ST_NX] = |rs_i;
  end

  // ----------------------------------------
  // Integer result and saturation
  // ----------------------------------------
  assign int_res = sign_i ? word_t'(-rounded_abs) : rounded_abs;

  // Negative value that stays nonzero after rounding
  assign neg_unsigned = sign_i & op_mod_i & ~is_zero_i & ~rounded_zero;
  assign int_special  = is_nan_i | is_inf_i | of_before_i | neg_unsigned;

  always_comb begin
    int_sat = {op_mod_i, {(`FCVT_WIDTH-1){1'b1}}};  // Positive max
    if (sign_i && !is_nan_i) int_sat = ~int_sat;    // Negative max or 0
    int_status = '0;
    if (int_special) int_status[ST_NV] = 1'b1;
    else int_status[ST_NX] = |rs_i;
  end

  // ----------------------------------------
  // Output select
  // ----------------------------------------
  assign result_o = (op_i == F2I) ? (int_special ? int_sat : int_res) : fp_res;
  assign status_o = (op_i == F2I) ? int_status : fp_status;

  // No divide in this unit
  always_comb begin
    assert (!status_o[ST_DZ]) else $error("fcvt_round: DZ raised");
  end

endmodule

`default_nettype wire

// ==== rtl/fcvt_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcvt_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  logic out_ready_i,
  input  logic flush_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic busy_o,
  output logic s1_en_o,   // Load stage 1 data
  output logic s2_en_o    // Load stage 2 data
);

  logic s1_valid_q;
  logic s2_valid_q;
  logic s2_ready;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  assign s2_ready   = ~s2_valid_q | out_ready_i;   // Empty or leaving
  assign in_ready_o = ~s1_valid_q | s2_ready;      // Stage 1 free or moving on
  assign s1_en_o    = in_valid_i & in_ready_o;
  assign s2_en_o    = s1_valid_q & s2_ready;

  assign out_valid_o = s2_valid_q;
  assign busy_o      = s1_valid_q | s2_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;  // Drop everything in flight
      s2_valid_q <= 1'b0;
    end else begin
      if (in_ready_o) s1_valid_q <= in_valid_i;
      if (s2_ready)   s2_valid_q <= s1_valid_q;
    end
  end

  // Output held until taken
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o)
    else $error("fcvt_pipe_ctrl: out_valid_o dropped before handshake");

endmodule

`default_nettype wire

// ==== rtl/fcvt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcvt_top import fcvt_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    in_valid_i,
  input  word_t   operand_i,
  input  op_e     op_i,
  input  logic    op_mod_i,
  input  rnd_e    rnd_i,
  input  logic    flush_i,
  input  logic    out_ready_i,
  output logic    in_ready_o,
  output word_t   result_o,
  output status_t status_o,
  output logic    out_valid_o,
  output logic    busy_o
);

  // Unpack outputs
  logic  u_sign, u_mant_zero, u_is_nan, u_is_snan, u_is_inf, u_is_zero;
  exp_t  u_exp;
  man_t  u_mant;
  // Stage 1 registers
  logic  s1_sign_q, s1_mant_zero_q, s1_is_nan_q, s1_is_snan_q, s1_is_inf_q, s1_is_zero_q;
  exp_t  s1_exp_q;
  man_t  s1_mant_q;
  op_e   s1_op_q;
  logic  s1_op_mod_q;
  rnd_e  s1_rnd_q;
  // Align and round
  word_t   a_abs;
  rs_t     a_rs;
  logic    a_of_before, a_uf_before;
  word_t   r_result;
  status_t r_status;
  logic    s1_en, s2_en;

  fcvt_pipe_ctrl fcvt_pipe_ctrl_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .out_ready_i ( out_ready_i ),
    .flush_i     ( flush_i     ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .busy_o      ( busy_o      ),
    .s1_en_o     ( s1_en       ),
    .s2_en_o     ( s2_en       )
  );

  // ----------------------------------------
  // Stage 0 / unpack
  // ----------------------------------------
  fcvt_unpack fcvt_unpack_i (
    .operand_i   ( operand_i   ),
    .op_i        ( op_i        ),
    .op_mod_i    ( op_mod_i    ),
    .sign_o      ( u_sign      ),
    .exp_o       ( u_exp       ),
    .mant_o      ( u_mant      ),
    .mant_zero_o ( u_mant_zero ),
    .is_nan_o    ( u_is_nan    ),
    .is_snan_o   ( u_is_snan   ),
    .is_inf_o    ( u_is_inf    ),
    .is_zero_o   ( u_is_zero   )
  );

  always_ff @(posedge clk_i) begin
    if (s1_en) begin
      s1_sign_q      <= u_sign;
      s1_exp_q       <= u_exp;
      s1_mant_q      <= u_mant;
      s1_mant_zero_q <= u_mant_zero;
      s1_is_nan_q    <= u_is_nan;
      s1_is_snan_q   <= u_is_snan;
      s1_is_inf_q    <= u_is_inf;
      s1_is_zero_q   <= u_is_zero;
      s1_op_q        <= op_i;
      s1_op_mod_q    <= op_mod_i;
      s1_rnd_q       <= rnd_i;
    end
  end

  // ----------------------------------------
  // Stage 1 / align and round
  // ----------------------------------------
  fcvt_align fcvt_align_i (
    .op_i        ( s1_op_q     ),
    .op_mod_i    ( s1_op_mod_q ),
    .sign_i      ( s1_sign_q   ),
    .exp_i       ( s1_exp_q    ),
    .mant_i      ( s1_mant_q   ),
    .is_inf_i    ( s1_is_inf_q ),
    .abs_o       ( a_abs       ),
    .rs_o        ( a_rs        ),
    .of_before_o ( a_of_before ),
    .uf_before_o ( a_uf_before )
  );

  fcvt_round fcvt_round_i (
    .op_i        ( s1_op_q        ),
    .op_mod_i    ( s1_op_mod_q    ),
    .rnd_i       ( s1_rnd_q       ),
    .sign_i      ( s1_sign_q      ),
    .mant_zero_i ( s1_mant_zero_q ),
    .is_nan_i    ( s1_is_nan_q    ),
    .is_snan_i   ( s1_is_snan_q   ),
    .is_inf_i    ( s1_is_inf_q    ),
    .is_zero_i   ( s1_is_zero_q   ),
    .abs_i       ( a_abs          ),
    .rs_i        ( a_rs           ),
    .of_before_i ( a_of_before    ),
    .uf_before_i ( a_uf_before    ),
    .result_o    ( r_result       ),
    .status_o    ( r_status       )
  );

  // Stage 2 drives the outputs directly
  always_ff @(posedge clk_i) begin
    if (s2_en) begin
      result_o <= r_result;
      status_o <= r_status;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands between edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker import fcvt_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    in_valid_i,
  input  logic    in_ready_i,
  input  logic    flush_i,
  input  logic    out_valid_i,
  input  logic    out_ready_i,
  input  word_t   result_i,
  input  status_t status_i,
  input  word_t   exp_result_i,   // Travels with the operand
  input  status_t exp_status_i,
  input  int      vec_id_i,
  output int      pass_cnt_o,
  output int      fail_cnt_o,
  output int      pending_o       // Items accepted, not yet out
);

  // Expected values in order of acceptance
  word_t   res_q[$];
  status_t st_q[$];
  int      id_q[$];
  word_t   want_res;
  status_t want_st;
  int      want_id;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_q.delete();
      st_q.delete();
      id_q.delete();
      pending_o = 0;
    end else begin
      // ----------------------------------------
      // Output handshake, compare and pop
      // ----------------------------------------
      if (out_valid_i && out_ready_i) begin
        if (res_q.size() == 0) begin
          $display("result %h left the DUT at %0t with no item in flight", result_i, $time);
          fail_cnt_o++;
        end else begin
          want_res = res_q.pop_front();
          want_st  = st_q.pop_front();
          want_id  = id_q.pop_front();
          if (result_i !== want_res || status_i !== want_st) begin
            $display("ERROR %0t: vector %0d result %h status %h, expected %h status %h",
                     $time, want_id, result_i, status_i, want_res, want_st);
            fail_cnt_o++;
          end else begin
            $display("vector %0d ok: result %h status %h", want_id, result_i, status_i);
            pass_cnt_o++;
          end
        end
      end

      // Flush wins over a new item on the same edge
      if (flush_i) begin
        if (res_q.size() != 0) $display("flush: %0d item(s) dropped", res_q.size());
        res_q.delete();
        st_q.delete();
        id_q.delete();
      end else if (in_valid_i && in_ready_i) begin
        res_q.push_back(exp_result_i);
        st_q.push_back(exp_status_i);
        id_q.push_back(vec_id_i);
      end
      pending_o = res_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_fcvt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fcvt import fcvt_pkg::*; ();

  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_VECS     = 64;

  // ----------------------------------------
  // DUT and checker signals
  // ----------------------------------------
  logic    clk;
  logic    rst_n;
  logic    in_valid;
  word_t   operand;
  op_e     op;
  logic    op_mod;
  rnd_e    rnd;
  logic    flush;
  logic    out_ready;
  logic    in_ready;
  word_t   result;
  status_t status;
  logic    out_valid;
  logic    busy;
  word_t   exp_result;
  status_t exp_status;
  int      vec_id;
  int      pass_cnt;
  int      fail_cnt;
  int      pending;

  // Stimulus table from the stim file
  logic [0:0] tab_op      [MAX_VECS];
  logic [0:0] tab_mod     [MAX_VECS];
  logic [2:0] tab_rnd     [MAX_VECS];
  word_t      tab_operand [MAX_VECS];
  word_t      tab_result  [MAX_VECS];
  status_t    tab_status  [MAX_VECS];
  int         n_vec;
  int         other_fails;  // Handshake and file problems
  int         ready_mode;   // 0 ready, 1 stall pattern, 2 held low
  bit         stim_loaded;

  tb_clk_gen #(
    .PERIOD_NS    ( PERIOD_NS    ),
    .RESET_CYCLES ( RESET_CYCLES )
  ) tb_clk_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  fcvt_top fcvt_top_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .operand_i   ( operand   ),
    .op_i        ( op        ),
    .op_mod_i    ( op_mod    ),
    .rnd_i       ( rnd       ),
    .flush_i     ( flush     ),
    .out_ready_i ( out_ready ),
    .in_ready_o  ( in_ready  ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .out_valid_o ( out_valid ),
    .busy_o      ( busy      )
  );

  tb_checker tb_checker_i (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .in_valid_i   ( in_valid   ),
    .in_ready_i   ( in_ready   ),
    .flush_i      ( flush      ),
    .out_valid_i  ( out_valid  ),
    .out_ready_i  ( out_ready  ),
    .result_i     ( result     ),
    .status_i     ( status     ),
    .exp_result_i ( exp_result ),
    .exp_status_i ( exp_status ),
    .vec_id_i     ( vec_id     ),
    .pass_cnt_o   ( pass_cnt   ),
    .fail_cnt_o   ( fail_cnt   ),
    .pending_o    ( pending    )
  );

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic load_stim();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_op, f_mod, f_rnd, f_operand, f_result, f_status;
    n_vec = 0;
    fd = $fopen("tests/fcvt_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/fcvt_stim.txt");
      other_fails++;
      return;
    end
    while (!$feof(fd) && n_vec < MAX_VECS) begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line[0] != "#") begin  // Skip column notes
        cnt = $sscanf(line, "%h %h %h %h %h %h",
                      f_op, f_mod, f_rnd, f_operand, f_result, f_status);
        if (cnt == 6) begin
          tab_op[n_vec]      = f_op[0];
          tab_mod[n_vec]     = f_mod[0];
          tab_rnd[n_vec]     = f_rnd[2:0];
          tab_operand[n_vec] = f_operand;
          tab_result[n_vec]  = f_result;
          tab_status[n_vec]  = f_status[4:0];
          n_vec++;
        end
      end
    end
    $fclose(fd);
    $display("%0d vectors loaded", n_vec);
  endtask

  // Called 2 ns after an edge, returns 2 ns after the handshake edge
  task automatic send_vec(input int idx);
    in_valid   = 1'b1;
    operand    = tab_operand[idx];
    op         = op_e'(tab_op[idx]);
    op_mod     = tab_mod[idx];
    rnd        = rnd_e'(tab_rnd[idx]);
    exp_result = tab_result[idx];
    exp_status = tab_status[idx];
    vec_id     = vec_id + 1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    do @(negedge clk); while (pending != 0 || busy);
    @(posedge clk);
    #2;
  endtask

  // Fill both stages under back-pressure, then flush them
  task automatic flush_in_flight();
    ready_mode = 2;
    @(posedge clk);
    #2;
    send_vec(0);
    send_vec(1);
    if (in_ready) begin
      $display("in_ready high with both stages full");
      other_fails++;
    end
    if (!busy || !out_valid) begin
      $display("busy or out_valid low with both stages full");
      other_fails++;
    end
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush      = 1'b0;
    ready_mode = 0;
    repeat (4) @(posedge clk);  // Longer than the pipeline
    @(negedge clk);
    if (busy || out_valid || pending != 0) begin
      $display("flushed items still in the pipeline");
      other_fails++;
    end
  endtask

  // Output ready, changed only here
  initial begin : ready_driver
    int cyc;
    out_ready = 1'b1;
    cyc       = 0;
    forever begin
      @(posedge clk);
      #2;
      cyc++;
      case (ready_mode)
        1:       out_ready = (cyc % 7) >= 4;  // Low four cycles of seven
        2:       out_ready = 1'b0;
        default: out_ready = 1'b1;
      endcase
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_seq
    in_valid    = 1'b0;
    operand     = '0;
    op          = F2I;
    op_mod      = 1'b0;
    rnd         = RNE;
    flush       = 1'b0;
    exp_result  = '0;
    exp_status  = '0;
    vec_id      = 0;
    other_fails = 0;
    ready_mode  = 0;
    load_stim();
    stim_loaded = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    if (out_valid || busy || !in_ready) begin
      $display("wrong state after reset: out_valid %b busy %b in_ready %b",
               out_valid, busy, in_ready);
      other_fails++;
    end
    @(posedge clk);
    #2;
    if (n_vec >= 2) begin
      $display("pass 1: streaming");
      for (int i = 0; i < n_vec; i++) send_vec(i);
      wait_drain();
      $display("pass 2: output back-pressure");
      ready_mode = 1;
      for (int i = 0; i < n_vec; i++) send_vec(i);
      wait_drain();
      ready_mode = 0;
      $display("flush with both stages full");
      flush_in_flight();
    end else begin
      $display("stim file holds fewer than two vectors");
    end
    $display("%0d passed, %0d failed, %0d other failures", pass_cnt, fail_cnt, other_fails);
    if (n_vec >= 2 && fail_cnt == 0 && other_fails == 0 && pass_cnt == 2 * n_vec) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget of 20 cycles per vector, flush test counted as two
  initial begin : watchdog
    longint limit_ns;
    wait (stim_loaded);
    limit_ns = longint'(20 * (n_vec + 2) + RESET_CYCLES) * PERIOD_NS;
    #(limit_ns);
    $display("timeout: outputs stopped arriving");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/fcvt_stim.txt ====
# op(0 F2I, 1 I2F) op_mod(1 unsigned) rnd operand result status, all hex
# status bits NV DZ OF UF NX from bit 4 down
1 0 0 00000001 3f800000 00
1 0 0 ffffffff bf800000 00
1 0 0 00000000 00000000 00
1 0 0 80000000 cf000000 00
1 0 0 00000064 42c80000 00
1 1 0 ffffffff 4f800000 01
1 1 1 ffffffff 4f7fffff 01
1 0 0 01000001 4b800000 01
1 0 3 01000001 4b800001 01
1 0 4 01000001 4b800001 01
1 0 0 01000003 4b800002 01
1 0 2 feffffff cb800001 01
0 0 0 40200000 00000002 01
0 0 4 40200000 00000003 01
0 0 0 40600000 00000004 01
0 0 2 c0200000 fffffffd 01
0 0 0 3f800000 00000001 00
0 0 0 3f000000 00000000 01
0 0 3 3e800000 00000001 01
0 0 3 00000001 00000001 01
0 0 0 4effffff 7fffff80 00
0 1 0 4f000000 80000000 00
0 1 0 bf800000 00000000 10
0 1 0 bf000000 00000000 01
0 0 0 7fc00000 7fffffff 10
0 1 0 7fc00000 ffffffff 10
0 0 0 7f800000 7fffffff 10
0 1 0 7f800000 ffffffff 10
0 0 0 ff800000 80000000 10
0 0 0 cf800000 80000000 10
0 0 0 4f000000 7fffffff 10

// ==== src.f ====
+incdir+rtl
rtl/fcvt_pkg.sv
rtl/fcvt_unpack.sv
rtl/fcvt_align.sv
rtl/fcvt_round.sv
rtl/fcvt_pipe_ctrl.sv
rtl/fcvt_top.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_fcvt.sv

// ==== Makefile ====
TOP = tb_fcvt

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
